// ==== verilog/pa_word_pkg.sv ====
`default_nettype none

package pa_word_pkg;

	// data path width, fixed by the architecture
	localparam int word_w = 16;

	// width of the short argument in the instruction word
	localparam int t_w = 10;

	// bit 0 is the most significant bit, as in the machine documentation
	typedef logic [0:word_w-1] word_t;

	// instruction word read as separate register fields
	typedef struct packed {
		logic [0:5] op;
		logic d;
		logic [0:2] a;
		logic [0:2] b;
		logic [0:2] c;
	} ir_long_t;

	// instruction word read as opcode plus signed short argument
	typedef struct packed {
		logic [0:5] op;
		logic signed [0:t_w-1] t;
	} ir_short_t;

	// one instruction word, two decodings
	typedef union packed {
		ir_long_t long_v;
		ir_short_t short_v;
	} ir_t;

endpackage

`default_nettype wire

// ==== verilog/pa_ctl_pkg.sv ====
`default_nettype none

package pa_ctl_pkg;

	// W bus source select
	typedef enum logic [2:0] {
		w_ir_t = 3'd0,
		w_kl = 3'd1,
		w_rdt = 3'd2,
		w_ki = 3'd3,
		w_at = 3'd4,
		w_ac = 3'd5,
		w_a = 3'd6
	} w_sel_t;

	// A operand source select
	typedef enum logic [1:0] {
		a_l = 2'd0,
		a_ir = 2'd1,
		a_ar = 2'd2,
		a_ic = 2'd3
	} a_sel_t;

	// 74181 S3..S0, bit 0 is S0
	typedef logic [3:0] alu_fn_t;

	// step used by the AR decrement
	localparam logic [0:15] ar_m4 = 16'd4;

endpackage

`default_nettype wire

// ==== verilog/pa_bus_w.sv ====
`default_nettype none

module pa_bus_w (
	input pa_ctl_pkg::w_sel_t w_sel,
	input logic w_dt,
	input pa_word_pkg::ir_t ir,
	input pa_word_pkg::word_t kl,
	input pa_word_pkg::word_t rdt,
	input pa_word_pkg::word_t ki,
	input pa_word_pkg::word_t at,
	input pa_word_pkg::word_t ac,
	input pa_word_pkg::word_t a,
	output pa_word_pkg::word_t w,
	output pa_word_pkg::word_t ddt
);

	import pa_word_pkg::*;
	import pa_ctl_pkg::*;

	word_t t_ext;

	// short argument, sign bit copied into the upper bits
	assign t_ext = {{(word_w - t_w){ir.short_v.t[0]}}, ir.short_v.t};

	always_comb begin
		case (w_sel)
			w_ir_t: w = t_ext;
			w_kl: w = kl;
			w_rdt: w = rdt;
			w_ki: w = ki;
			w_at: w = at;
			w_ac: w = ac;
			w_a: w = a;
			default: w = '0;
		endcase
	end

	// data bus is active low, all ones when not driven
	assign ddt = w_dt ? ~w : '1;

endmodule

`default_nettype wire

// ==== verilog/pa_alu.sv ====
`default_nettype none

module pa_alu (
	input logic clk_sys,
	input logic rst_n,
	input pa_ctl_pkg::alu_fn_t alu_fn,
	input logic alu_m,
	input logic alu_cin,
	input logic as2,
	input logic strob1,
	input pa_word_pkg::word_t a,
	input pa_word_pkg::word_t ac,
	input pa_word_pkg::ir_t ir,
	output pa_word_pkg::word_t f,
	output logic s0,
	output logic carry,
	output logic s_1,
	output logic zs,
	output logic exx,
	output logic wzi
);

	import pa_word_pkg::*;

	word_t x;
	word_t y;
	// bit 0 holds the carry out
	logic [0:word_w] sum;

	// 74181 internal terms, A = a and B = ac
	// x picks A OR (B and/or ~B) by S0/S1, y picks A AND (B and/or ~B) by S3/S2
	always_comb begin
		x = a | (ac & {word_w{alu_fn[0]}}) | (~ac & {word_w{alu_fn[1]}});
		y = (a & ac & {word_w{alu_fn[3]}}) | (a & ~ac & {word_w{alu_fn[2]}});
	end

	// arithmetic mode is x plus y plus carry in
	assign sum = {1'b0, x} + {1'b0, y} + {{word_w{1'b0}}, alu_cin};

	// logic mode uses the same terms without carries
	assign f = alu_m ? ~(x ^ y) : sum[1:word_w];

	assign carry = sum[0];
	assign s0 = f[0];

	// extended sign, only meaningful for arithmetic
	assign s_1 = ~alu_m & (a[0] ^ ac[0] ^ carry);

	assign zs = (f == '0) && !s_1;

	// d field chooses which end of A is tested
	assign exx = ir.long_v.d ? ~a[15] : ~a[0];

	// zero flag latched in the second half of the cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wzi <= 1'b0;
		end else if (strob1 && as2) begin
			wzi <= zs;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pa_regs.sv ====
`default_nettype none

module pa_regs (
	input logic clk_sys,
	input logic rst_n,
	input logic strob1,
	input logic strob2,
	input logic as2,
	input logic w_ac,
	input logic w_ar,
	input logic w_ic,
	input logic arp1,
	input logic arm4,
	input logic icp1,
	input logic off,
	input pa_word_pkg::word_t w,
	output pa_word_pkg::word_t ac,
	output pa_word_pkg::word_t ar,
	output pa_word_pkg::word_t ic,
	output logic arz
);

	import pa_ctl_pkg::*;

	logic stroba;
	logic strobb;
	logic strob_w;
	logic wr_ac;
	logic wr_ar;
	logic wr_ic;

	// strob1 in the first phase, strob2 in the second
	assign stroba = strob1 & ~as2;
	assign strobb = strob2 & as2;
	assign strob_w = stroba | strobb;

	assign wr_ac = w_ac & strob_w;
	assign wr_ar = w_ar & strob_w;
	assign wr_ic = w_ic & strob_w;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
		end else if (wr_ac) begin
			ac <= w;
		end
	end

	// load, then +1, then -4
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ar <= '0;
		end else if (wr_ar) begin
			ar <= w;
		end else if (arp1 && stroba) begin
			ar <= ar + 16'd1;
		end else if (arm4) begin
			ar <= ar - ar_m4;
		end
	end

	// off wins over everything
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (wr_ic) begin
			ic <= w;
		end else if (icp1 && strob1) begin
			ic <= ic + 16'd1;
		end
	end

	// address above the first 256 words
	assign arz = |ar[0:7];

endmodule

`default_nettype wire

// ==== verilog/pa_at.sv ====
`default_nettype none

module pa_at (
	input logic clk_sys,
	input logic rst_n,
	input logic strob1,
	input logic as2,
	input logic w_at,
	input logic at_sh,
	input logic at_sl,
	input pa_word_pkg::word_t f,
	output pa_word_pkg::word_t at,
	output logic at15
);

	logic at_load;

	assign at_load = w_at & strob1 & as2;

	// load wins over shift
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			at <= '0;
		end else if (at_load) begin
			at <= f;
		end else if (at_sh) begin
			// serial bit enters at the most significant end
			at <= {at_sl, at[0:14]};
		end
	end

	assign at15 = at[15];

endmodule

`default_nettype wire

// ==== verilog/pa_a_bus.sv ====
`default_nettype none

module pa_a_bus (
	input pa_ctl_pkg::a_sel_t a_sel,
	input pa_word_pkg::word_t l,
	input pa_word_pkg::word_t ar,
	input pa_word_pkg::word_t ic,
	input pa_word_pkg::word_t kl,
	input pa_word_pkg::ir_t ir,
	input logic ar_ad,
	input logic ic_ad,
	input logic barnb,
	output pa_word_pkg::word_t a,
	output pa_word_pkg::word_t dad,
	output logic zga
);

	import pa_word_pkg::*;
	import pa_ctl_pkg::*;

	logic zga_hi;
	logic zga_lo;

	always_comb begin
		case (a_sel)
			a_l: a = l;
			a_ir: a = ir;
			a_ar: a = ar;
			a_ic: a = ic;
			default: a = '0;
		endcase
	end

	// address bus is active low, AR and IC may overlap
	assign dad = ~((ar & {word_w{ar_ad}}) | (ic & {word_w{ic_ad}}));

	// upper byte carries the block number bit in place of dad[0]
	assign zga_hi = (kl[0:7] == {barnb, dad[1:7]});
	assign zga_lo = (kl[8:15] == dad[8:15]);
	assign zga = zga_hi & zga_lo;

endmodule

`default_nettype wire

// ==== verilog/pa.sv ====
`default_nettype none

module pa (
	input logic clk_sys,
	input logic rst_n,
	input pa_word_pkg::ir_t ir,
	input pa_word_pkg::word_t ki,
	input pa_word_pkg::word_t rdt,
	input pa_word_pkg::word_t kl,
	input pa_word_pkg::word_t l,
	input pa_ctl_pkg::w_sel_t w_sel,
	input logic w_dt,
	input pa_ctl_pkg::a_sel_t a_sel,
	input pa_ctl_pkg::alu_fn_t alu_fn,
	input logic alu_m,
	input logic alu_cin,
	input logic strob1,
	input logic strob2,
	input logic as2,
	input logic w_ac,
	input logic w_ar,
	input logic w_ic,
	input logic w_at,
	input logic arp1,
	input logic arm4,
	input logic icp1,
	input logic off,
	input logic at_sh,
	input logic at_sl,
	input logic ar_ad,
	input logic ic_ad,
	input logic barnb,
	output pa_word_pkg::word_t w,
	output pa_word_pkg::word_t ddt,
	output pa_word_pkg::word_t dad,
	output logic s0,
	output logic carry,
	output logic zs,
	output logic exx,
	output logic exy,
	output logic at15,
	output logic wzi,
	output logic arz,
	output logic zga
);

	import pa_word_pkg::*;

	word_t a;
	word_t f;
	word_t ac;
	word_t ar;
	word_t ic;
	word_t at;

	pa_bus_w u_bus_w (
		.w_sel(w_sel),
		.w_dt(w_dt),
		.ir(ir),
		.kl(kl),
		.rdt(rdt),
		.ki(ki),
		.at(at),
		.ac(ac),
		.a(a),
		.w(w),
		.ddt(ddt)
	);

	// extended sign is only used internally for zs
	pa_alu u_alu (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.alu_fn(alu_fn),
		.alu_m(alu_m),
		.alu_cin(alu_cin),
		.as2(as2),
		.strob1(strob1),
		.a(a),
		.ac(ac),
		.ir(ir),
		.f(f),
		.s0(s0),
		.carry(carry),
		.s_1(),
		.zs(zs),
		.exx(exx),
		.wzi(wzi)
	);

	pa_regs u_regs (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.strob1(strob1),
		.strob2(strob2),
		.as2(as2),
		.w_ac(w_ac),
		.w_ar(w_ar),
		.w_ic(w_ic),
		.arp1(arp1),
		.arm4(arm4),
		.icp1(icp1),
		.off(off),
		.w(w),
		.ac(ac),
		.ar(ar),
		.ic(ic),
		.arz(arz)
	);

	pa_at u_at (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.strob1(strob1),
		.as2(as2),
		.w_at(w_at),
		.at_sh(at_sh),
		.at_sl(at_sl),
		.f(f),
		.at(at),
		.at15(at15)
	);

	pa_a_bus u_a_bus (
		.a_sel(a_sel),
		.l(l),
		.ar(ar),
		.ic(ic),
		.kl(kl),
		.ir(ir),
		.ar_ad(ar_ad),
		.ic_ad(ic_ad),
		.barnb(barnb),
		.a(a),
		.dad(dad),
		.zga(zga)
	);

	// shift uses the AT end, otherwise the A sign
	assign exy = at_sh ? ~at[15] : ~a[0];

endmodule

`default_nettype wire

// ==== tb/pa_checker.sv ====
`default_nettype none

module pa_checker (
	input logic clk_sys,
	input logic rst_n,
	input pa_word_pkg::word_t ir,
	input pa_word_pkg::word_t ki,
	input pa_word_pkg::word_t rdt,
	input pa_word_pkg::word_t kl,
	input pa_word_pkg::word_t l,
	input pa_ctl_pkg::w_sel_t w_sel,
	input logic w_dt,
	input pa_ctl_pkg::a_sel_t a_sel,
	input pa_ctl_pkg::alu_fn_t alu_fn,
	input logic alu_m,
	input logic alu_cin,
	input logic strob1,
	input logic strob2,
	input logic as2,
	input logic w_ac,
	input logic w_ar,
	input logic w_ic,
	input logic w_at,
	input logic arp1,
	input logic arm4,
	input logic icp1,
	input logic off,
	input logic at_sh,
	input logic at_sl,
	input logic ar_ad,
	input logic ic_ad,
	input logic barnb,
	input pa_word_pkg::word_t w,
	input pa_word_pkg::word_t ddt,
	input pa_word_pkg::word_t dad,
	input logic s0,
	input logic carry,
	input logic zs,
	input logic exx,
	input logic exy,
	input logic at15,
	input logic wzi,
	input logic arz,
	input logic zga,
	input logic check,
	input logic finish_req,
	input logic [8*16-1:0] test_name,
	output logic report_done,
	output int n_err,
	output int n_chk
);

	import pa_word_pkg::*;
	import pa_ctl_pkg::*;

	// shadow copies of the DUT state
	word_t m_ac;
	word_t m_ar;
	word_t m_ic;
	word_t m_at;
	logic m_wzi;

	logic [8*16-1:0] cur_name;
	int cur_chk;
	int cur_err;

	initial begin
		n_err = 0;
		n_chk = 0;
		cur_chk = 0;
		cur_err = 0;
		cur_name = '0;
		report_done = 1'b0;
	end

	// 74181 in active-high form, returns {carry, f}
	function logic [16:0] alu_ref(input word_t a, input word_t b, input logic [3:0] fn,
		input logic m, input logic cin);
		word_t p;
		word_t q;
		word_t lg;
		logic [16:0] s;
		case (fn)
			4'h0: lg = ~a;
			4'h1: lg = ~(a | b);
			4'h2: lg = ~a & b;
			4'h3: lg = 16'h0000;
			4'h4: lg = ~(a & b);
			4'h5: lg = ~b;
			4'h6: lg = a ^ b;
			4'h7: lg = a & ~b;
			4'h8: lg = ~a | b;
			4'h9: lg = ~(a ^ b);
			4'ha: lg = b;
			4'hb: lg = a & b;
			4'hc: lg = 16'hffff;
			4'hd: lg = a | ~b;
			4'he: lg = a | b;
			default: lg = a;
		endcase
		// arithmetic result written as p plus q plus carry in
		case (fn)
			4'h0: {p, q} = {a, 16'h0000};
			4'h1: {p, q} = {a | b, 16'h0000};
			4'h2: {p, q} = {a | ~b, 16'h0000};
			4'h3: {p, q} = {16'hffff, 16'h0000};
			4'h4: {p, q} = {a, a & ~b};
			4'h5: {p, q} = {a | b, a & ~b};
			4'h6: {p, q} = {a, ~b};
			4'h7: {p, q} = {a & ~b, 16'hffff};
			4'h8: {p, q} = {a, a & b};
			4'h9: {p, q} = {a, b};
			4'ha: {p, q} = {a | ~b, a & b};
			4'hb: {p, q} = {a & b, 16'hffff};
			4'hc: {p, q} = {a, a};
			4'hd: {p, q} = {a | b, a};
			4'he: {p, q} = {a | ~b, a};
			default: {p, q} = {a, 16'hffff};
		endcase
		s = {1'b0, p} + {1'b0, q} + {16'h0000, cin};
		return {s[16], m ? lg : s[15:0]};
	endfunction

	function word_t a_ref();
		case (a_sel)
			a_l: return l;
			a_ir: return ir;
			a_ar: return m_ar;
			default: return m_ic;
		endcase
	endfunction

	function word_t w_ref(input word_t ea);
		case (w_sel)
			w_ir_t: return {{6{ir[6]}}, ir[6:15]};
			w_kl: return kl;
			w_rdt: return rdt;
			w_ki: return ki;
			pa_ctl_pkg::w_at: return m_at;
			pa_ctl_pkg::w_ac: return m_ac;
			w_a: return ea;
			default: return 16'h0000;
		endcase
	endfunction

	// {w, ddt, dad, s0, carry, zs, exx, exy, at15, wzi, arz, zga}
	function logic [56:0] pa_model();
		word_t ea;
		word_t ew;
		word_t ef;
		word_t edad;
		logic [16:0] cf;
		logic es1;
		logic ezs;
		ea = a_ref();
		ew = w_ref(ea);
		cf = alu_ref(ea, m_ac, alu_fn, alu_m, alu_cin);
		ef = cf[15:0];
		es1 = ~alu_m & (ea[0] ^ m_ac[0] ^ cf[16]);
		ezs = (ef == 16'h0000) & ~es1;
		edad = ~((m_ar & {16{ar_ad}}) | (m_ic & {16{ic_ad}}));
		return {ew, w_dt ? ~ew : 16'hffff, edad, ef[0], cf[16], ezs,
			ir[6] ? ~ea[15] : ~ea[0], at_sh ? ~m_at[15] : ~ea[0], m_at[15], m_wzi,
			|m_ar[0:7], kl == {barnb, edad[1:15]}};
	endfunction

	always @(posedge clk_sys or negedge rst_n) begin
		logic [56:0] e;
		logic [16:0] cf;
		logic stra;
		logic strw;
		if (!rst_n) begin
			m_ac <= '0;
			m_ar <= '0;
			m_ic <= '0;
			m_at <= '0;
			m_wzi <= 1'b0;
		end else begin
			e = pa_model();
			cf = alu_ref(a_ref(), m_ac, alu_fn, alu_m, alu_cin);
			stra = strob1 & ~as2;
			strw = stra | (strob2 & as2);
			if (w_ac && strw)
				m_ac <= e[56:41];
			if (w_ar && strw)
				m_ar <= e[56:41];
			else if (arp1 && stra)
				m_ar <= m_ar + 16'd1;
			else if (arm4)
				m_ar <= m_ar - 16'd4;
			if (off)
				m_ic <= '0;
			else if (w_ic && strw)
				m_ic <= e[56:41];
			else if (icp1 && strob1)
				m_ic <= m_ic + 16'd1;
			if (w_at && strob1 && as2)
				m_at <= cf[15:0];
			else if (at_sh)
				m_at <= {at_sl, m_at[0:14]};
			if (strob1 && as2)
				m_wzi <= e[6];
		end
	end

	task report_test();
		$display("test %0s: %0d checks, %0d mismatches", cur_name, cur_chk, cur_err);
	endtask

	// compares before the shadow state moves on this edge
	always @(posedge clk_sys) begin
		logic [56:0] exp_v;
		logic [56:0] act_v;
		if (check) begin
			if (test_name != cur_name) begin
				if (cur_chk > 0)
					report_test();
				cur_name = test_name;
				cur_chk = 0;
				cur_err = 0;
			end
			exp_v = pa_model();
			act_v = {w, ddt, dad, s0, carry, zs, exx, exy, at15, wzi, arz, zga};
			n_chk++;
			cur_chk++;
			if (exp_v !== act_v) begin
				$display("Mismatch %0s: expected %h, actual %h", test_name, exp_v, act_v);
				n_err++;
				cur_err++;
			end
		end
		if (finish_req && !report_done) begin
			if (cur_chk > 0)
				report_test();
			$display("checks %0d, mismatches %0d", n_chk, n_err);
			report_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_pa.sv ====
`default_nettype none

module tb_pa;

	import pa_word_pkg::*;
	import pa_ctl_pkg::*;

	logic clk_sys;
	logic rst_n;
	ir_t ir;
	word_t ki, rdt, kl, l;
	w_sel_t w_sel;
	a_sel_t a_sel;
	alu_fn_t alu_fn;
	logic w_dt, alu_m, alu_cin, strob1, strob2, as2;
	logic w_ac, w_ar, w_ic, w_at, arp1, arm4, icp1, off;
	logic at_sh, at_sl, ar_ad, ic_ad, barnb;
	word_t w, ddt, dad;
	logic s0, carry, zs, exx, exy, at15, wzi, arz, zga;

	logic check;
	logic finish_req;
	logic report_done;
	logic [8*16-1:0] test_name;
	int n_err;
	int n_chk;
	int seed;

	pa i_dut (.*);

	pa_checker u_chk (.*);

	always #20 clk_sys = ~clk_sys;

	function word_t rnd16();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function logic rnd1();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	task step();
		@(negedge clk_sys);
	endtask

	// one cycle with the checker sampling at the rising edge
	task chk();
		check = 1'b1;
		step();
		check = 1'b0;
	endtask

	// loads AC (0), AR (1) or IC (2) in the first phase
	task load_reg(input int which, input word_t v);
		rdt = v;
		w_sel = w_rdt;
		as2 = 1'b0;
		strob1 = 1'b1;
		w_ac = (which == 0);
		w_ar = (which == 1);
		w_ic = (which == 2);
		step();
		strob1 = 1'b0;
		w_ac = 1'b0;
		w_ar = 1'b0;
		w_ic = 1'b0;
	endtask

	initial begin
		int n;
		int k;
		int ph;
		word_t r16;
		word_t d_exp;
		word_t v_ar;
		word_t v_ic;
		seed = 67019;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		ir = '0;
		{ki, rdt, kl, l} = '0;
		w_sel = w_ir_t;
		a_sel = a_l;
		alu_fn = 4'h0;
		{w_dt, alu_m, alu_cin, strob1, strob2, as2} = '0;
		{w_ac, w_ar, w_ic, w_at, arp1, arm4, icp1, off} = '0;
		{at_sh, at_sl, ar_ad, ic_ad, barnb} = '0;
		check = 1'b0;
		finish_req = 1'b0;
		test_name = "none";
		repeat (3) step();
		rst_n = 1'b1;

		test_name = "reset";
		w_sel = pa_ctl_pkg::w_ac;
		chk();
		w_sel = pa_ctl_pkg::w_at;
		chk();
		w_sel = w_a;
		a_sel = a_ar;
		chk();
		a_sel = a_ic;
		chk();

		test_name = "load";
		for (ph = 0; ph < 2; ph++) begin
			for (k = 0; k < 3; k++) begin
				rdt = rnd16();
				w_sel = w_rdt;
				as2 = ph[0];
				strob1 = ~ph[0];
				strob2 = ph[0];
				w_ac = (k == 0);
				w_ar = (k == 1);
				w_ic = (k == 2);
				step();
				// strobe in the wrong phase must not write
				rdt = rnd16();
				strob1 = ph[0];
				strob2 = ~ph[0];
				step();
				{strob1, strob2, as2, w_ac, w_ar, w_ic} = '0;
				if (k == 0) begin
					w_sel = pa_ctl_pkg::w_ac;
				end else begin
					w_sel = w_a;
				end
				if (k == 2) begin
					a_sel = a_ic;
				end else begin
					a_sel = a_ar;
				end
				chk();
			end
		end

		test_name = "alu";
		for (n = 0; n < 200; n++) begin
			load_reg(0, rnd16());
			l = rnd16();
			a_sel = a_l;
			r16 = rnd16();
			alu_fn = r16[12:15];
			alu_m = r16[0];
			alu_cin = r16[1];
			ir = rnd16();
			// f goes into AT and zs into wzi on this edge
			w_sel = w_a;
			strob1 = 1'b1;
			as2 = 1'b1;
			w_at = 1'b1;
			chk();
			{strob1, as2, w_at} = '0;
			w_sel = pa_ctl_pkg::w_at;
			chk();
		end

		test_name = "count";
		for (k = 0; k < 2; k++) begin
			load_reg(1, (k == 0) ? 16'hfffe : 16'h0006);
			load_reg(2, 16'hffff);
			w_sel = w_a;
			for (n = 0; n < 40; n++) begin
				r16 = rnd16();
				arp1 = r16[0];
				arm4 = r16[1];
				icp1 = r16[2];
				off = (r16[3:5] == 3'b000);
				strob1 = r16[6];
				// as2 separates the AR and IC increment strobes
				as2 = r16[8];
				if (r16[7]) begin
					a_sel = a_ic;
				end else begin
					a_sel = a_ar;
				end
				chk();
			end
			{arp1, arm4, icp1, off, strob1, as2} = '0;
		end

		test_name = "shift";
		l = rnd16();
		a_sel = a_l;
		alu_fn = 4'hf;
		alu_m = 1'b1;
		w_at = 1'b1;
		strob1 = 1'b1;
		as2 = 1'b1;
		step();
		{w_at, strob1, as2} = '0;
		w_sel = pa_ctl_pkg::w_at;
		at_sh = 1'b1;
		for (n = 0; n < 16; n++) begin
			at_sl = rnd1();
			chk();
		end
		at_sh = 1'b0;

		test_name = "address";
		for (n = 0; n < 24; n++) begin
			v_ar = rnd16();
			v_ic = rnd16();
			load_reg(1, v_ar);
			load_reg(2, v_ic);
			barnb = rnd1();
			w_dt = rnd1();
			ir = rnd16();
			w_sel = w_ir_t;
			for (k = 0; k < 4; k++) begin
				ar_ad = k[0];
				ic_ad = k[1];
				// odd rounds build a key that matches the address
				d_exp = ~((v_ar & {16{ar_ad}}) | (v_ic & {16{ic_ad}}));
				if (n[0]) begin
					kl = {barnb, d_exp[1:15]};
				end else begin
					kl = rnd16();
				end
				chk();
			end
		end

		finish_req = 1'b1;
		n = 0;
		while (!report_done && n < 10) begin
			step();
			n++;
		end
		if (!report_done) begin
			$display("checker did not report within 10 cycles");
			$display("** FAIL **");
		end else if (n_err == 0 && n_chk > 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/pa_word_pkg.sv
verilog/pa_ctl_pkg.sv
verilog/pa_bus_w.sv
verilog/pa_alu.sv
verilog/pa_regs.sv
verilog/pa_at.sv
verilog/pa_a_bus.sv
verilog/pa.sv
tb/pa_checker.sv
tb/tb_pa.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_pa
FLAGS ?= --binary --timing

SRCS := $(shell grep -v '^+' sim.f)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sim.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
